//--- project.f
+incdir+test
hdl/lsu_pkg.sv
hdl/data_req_if.sv
hdl/wpt_trigger.sv
hdl/wpt_filter.sv
hdl/data_mpu.sv
hdl/txn_counter.sv
hdl/data_mem.sv
hdl/data_subsys_top.sv
test/tb_data_subsys.sv

//--- run.sh
#!/bin/sh
# Build the data subsystem testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --x-initial 0 \
  --top-module tb_data_subsys -f project.f -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -q "All checks passed" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

//--- test/tb_tasks.svh
/*
 * Data subsystem testbench helpers
 * Request driving, watchpoint programming, response prediction and compares
 */

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

////////////////////////////////////////////////////////////////////////////
// Failure reporting and compares
////////////////////////////////////////////////////////////////////////////

task automatic abort_run(input string why);
  $display("%s", why);
  $display("Checks failed");
  $fatal(1);
endtask

// Fields are printed as rdata, err, status and wpt_match
task automatic check_resp(input lsu_pkg::data_resp_t got, input lsu_pkg::data_resp_t exp);
  if (got !== exp) begin
    abort_run($sformatf("error %0t: resp %h %b %s %b, expected %h %b %s %b", $time,
      got.bus_resp.rdata, got.bus_resp.err, got.mpu_status.name(), got.wpt_match,
      exp.bus_resp.rdata, exp.bus_resp.err, exp.mpu_status.name(), exp.wpt_match));
  end
endtask

task automatic check_match(input logic got, input logic exp);
  if (got !== exp) begin
    abort_run($sformatf("error %0t: wpt_match_o is %b, expected %b", $time, got, exp));
  end
endtask

task automatic check_cycle(input int got, input int exp);
  if (got != exp) begin
    abort_run($sformatf("error %0t: response in cycle %0d, expected cycle %0d",
      $time, got, exp));
  end
endtask

////////////////////////////////////////////////////////////////////////////
// Response prediction
////////////////////////////////////////////////////////////////////////////

// Queues the response a request should get and updates the memory model
// A due cycle of -1 means only the order is checked
task automatic push_expected(input logic [31:0] addr, input logic we, input logic [3:0] be,
                             input logic [31:0] wdata, input logic hit, input int due);
  lsu_pkg::data_resp_t r;
  int unsigned w;
  r = '0;
  w = addr[31:2];
  if (hit) begin
    // Watchpoint answer carries no data and never touches memory
    r.wpt_match = 1'b1;
    due = -1;
  end else if (we && (addr >= RO_BASE)) begin
    r.mpu_status = lsu_pkg::MPU_WR_FAULT;
  end else if (w >= MEM_WORDS) begin
    r.bus_resp.err = 1'b1;
  end else begin
    // A write answers with the word as it stood before
    r.bus_resp.rdata = model_mem[w];
    if (we) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) model_mem[w][8*b +: 8] = wdata[8*b +: 8];
      end
    end
  end
  exp_q.push_back(r);
  exp_cyc_q.push_back(due);
endtask

////////////////////////////////////////////////////////////////////////////
// Drivers
////////////////////////////////////////////////////////////////////////////

// Called on a falling edge, returns on the falling edge after acceptance
// Valid stays high on return so the next call follows without a gap
task automatic issue_req(input logic [31:0] addr, input logic we, input logic [3:0] be,
                         input logic [31:0] wdata, input logic hit);
  req_valid = 1'b1;
  req_addr  = addr;
  req_we    = we;
  req_be    = be;
  req_wdata = wdata;
  #1;
  while (!req_ready) begin
    @(negedge clk);
    #1;
  end
  check_match(wpt_match, hit);
  // A match without wait is consumed and never answered
  if (!hit || wpt_wait) begin
    push_expected(addr, we, be, wdata, hit, cyc + 1);
  end
  @(negedge clk);
endtask

task automatic program_wpt(input logic [IDX_W-1:0] idx, input logic [31:0] addr,
                           input logic load, input logic store, input logic en);
  req_valid = 1'b0;
  cfg_we    = 1'b1;
  cfg_idx   = idx;
  cfg_addr  = addr;
  cfg_load  = load;
  cfg_store = store;
  cfg_en    = en;
  @(negedge clk);
  cfg_we = 1'b0;
endtask

// Idles the request port until every expected response has been seen
task automatic wait_drain();
  req_valid = 1'b0;
  while (exp_q.size() != 0) begin
    @(negedge clk);
  end
  repeat (2) @(negedge clk);
endtask

`endif

//--- test/tb_data_subsys.sv
/*
 * Data subsystem testbench
 * Directed tests for memory access, MPU faults and watchpoints
 */

`timescale 1ns/1ps

module tb_data_subsys;

  localparam int unsigned NUM_WPT         = 2;
  localparam logic [31:0] RO_BASE         = 32'h100;
  localparam int unsigned MEM_WORDS       = 128;
  localparam int unsigned MAX_OUTSTANDING = 2;
  localparam int unsigned IDX_W           = (NUM_WPT > 1) ? $clog2(NUM_WPT) : 1;
  // All tests together take a few hundred cycles
  localparam int          TIMEOUT_CYCLES  = 2000;

  logic                 clk;
  logic                 rst_n;
  logic                 req_valid;
  logic                 req_ready;
  logic [31:0]          req_addr;
  logic                 req_we;
  logic [3:0]           req_be;
  logic [31:0]          req_wdata;
  logic                 resp_valid;
  logic [31:0]          resp_rdata;
  logic                 resp_err;
  lsu_pkg::mpu_status_e resp_mpu_status;
  logic                 resp_wpt_match;
  logic                 wpt_wait;
  logic                 wpt_match;
  logic                 cfg_we;
  logic [IDX_W-1:0]     cfg_idx;
  logic [31:0]          cfg_addr;
  logic                 cfg_load;
  logic                 cfg_store;
  logic                 cfg_en;

  int                   cyc = 0;
  logic [31:0]          model_mem [MEM_WORDS];
  lsu_pkg::data_resp_t  exp_q [$];
  int                   exp_cyc_q [$];

  data_subsys_top #(
    .NUM_WPT(NUM_WPT), .RO_BASE(RO_BASE), .MEM_WORDS(MEM_WORDS),
    .MAX_OUTSTANDING(MAX_OUTSTANDING)
  ) u_data_subsys_top (
    .clk, .rst_n, .req_valid_i(req_valid), .req_ready_o(req_ready),
    .req_addr_i(req_addr), .req_we_i(req_we), .req_be_i(req_be), .req_wdata_i(req_wdata),
    .resp_valid_o(resp_valid), .resp_rdata_o(resp_rdata), .resp_err_o(resp_err),
    .resp_mpu_status_o(resp_mpu_status), .resp_wpt_match_o(resp_wpt_match),
    .wpt_wait_i(wpt_wait), .wpt_match_o(wpt_match),
    .cfg_we_i(cfg_we), .cfg_idx_i(cfg_idx), .cfg_addr_i(cfg_addr),
    .cfg_load_i(cfg_load), .cfg_store_i(cfg_store), .cfg_en_i(cfg_en)
  );

  `include "tb_tasks.svh"

  always #2 clk = ~clk;

  // Cycle count for response timing and the run limit
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("Run timed out after %0d cycles", cyc));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response monitor
  ////////////////////////////////////////////////////////////////////////////

  // Outputs change on the rising edge, so they are sampled on the falling one
  always @(negedge clk) begin : resp_monitor
    lsu_pkg::data_resp_t got;
    int                  due;
    if (rst_n && resp_valid) begin
      if (exp_q.size() == 0) begin
        abort_run("A response arrived while no request was waiting for one");
      end else begin
        got.bus_resp.rdata = resp_rdata;
        got.bus_resp.err   = resp_err;
        got.mpu_status     = resp_mpu_status;
        got.wpt_match      = resp_wpt_match;
        check_resp(got, exp_q.pop_front());
        due = exp_cyc_q.pop_front();
        if (due >= 0) check_cycle(cyc, due);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  // Random partial writes into the writable region, then read back
  task automatic test_rw_random();
    logic [31:0] addr [16];
    for (int i = 0; i < 16; i++) begin
      addr[i] = $urandom_range(RO_BASE / 4 - 1) * 4;
      issue_req(addr[i], 1'b1, 4'($urandom_range(15, 1)), $urandom(), 1'b0);
    end
    for (int i = 0; i < 16; i++) begin
      issue_req(addr[i], 1'b0, 4'hf, 32'h0, 1'b0);
    end
    wait_drain();
  endtask

  // Writes at and above RO_BASE fault while reads there pass
  task automatic test_ro_region();
    issue_req(RO_BASE - 4, 1'b1, 4'hf, 32'ha5a5_5a5a, 1'b0);
    issue_req(RO_BASE, 1'b1, 4'hf, 32'hdead_beef, 1'b0);
    issue_req(32'h1f0, 1'b1, 4'h3, 32'h1234_5678, 1'b0);
    issue_req(RO_BASE, 1'b0, 4'hf, 32'h0, 1'b0);
    issue_req(32'h1f0, 1'b0, 4'hf, 32'h0, 1'b0);
    issue_req(RO_BASE - 4, 1'b0, 4'hf, 32'h0, 1'b0);
    wait_drain();
  endtask

  task automatic test_out_of_range();
    issue_req(MEM_WORDS * 4, 1'b0, 4'hf, 32'h0, 1'b0);
    issue_req(32'hffff_fffc, 1'b0, 4'hf, 32'h0, 1'b0);
    issue_req(32'h20, 1'b0, 4'hf, 32'h0, 1'b0);
    wait_drain();
  endtask

  // Store on a watched word with wait, behind two ordinary requests
  task automatic test_wpt_wait();
    program_wpt(0, 32'h40, 1'b0, 1'b1, 1'b1);
    wpt_wait = 1'b1;
    issue_req(32'h10, 1'b0, 4'hf, 32'h0, 1'b0);
    issue_req(32'h14, 1'b1, 4'hf, 32'h0bad_f00d, 1'b0);
    issue_req(32'h40, 1'b1, 4'hf, 32'hcafe_0001, 1'b1);
    issue_req(32'h40, 1'b0, 4'hf, 32'h0, 1'b0);
    wait_drain();
    wpt_wait = 1'b0;
    program_wpt(0, 32'h40, 1'b0, 1'b0, 1'b0);
  endtask

  // Matches without wait are swallowed and misses go through untouched
  task automatic test_wpt_nowait();
    program_wpt(0, 32'h48, 1'b1, 1'b1, 1'b1);
    program_wpt(1, 32'h4c, 1'b0, 1'b1, 1'b1);
    issue_req(32'h48, 1'b1, 4'hf, 32'h7777_0000, 1'b1);
    issue_req(32'h48, 1'b0, 4'hf, 32'h0, 1'b1);
    issue_req(32'h50, 1'b0, 4'hf, 32'h0, 1'b0);
    issue_req(32'h4c, 1'b0, 4'hf, 32'h0, 1'b0);
    issue_req(32'h4c, 1'b1, 4'hf, 32'h8888_0000, 1'b1);
    program_wpt(0, 32'h48, 1'b1, 1'b1, 1'b0);
    issue_req(32'h48, 1'b0, 4'hf, 32'h0, 1'b0);
    wait_drain();
  endtask

  // Faults stall the port for a cycle, so valid is held across it
  task automatic test_back_to_back();
    logic [31:0] a;
    for (int i = 0; i < 12; i++) begin
      a = $urandom_range(RO_BASE / 4 - 1) * 4;
      case (i % 4)
        0: issue_req(a, 1'b1, 4'hf, $urandom(), 1'b0);
        1: issue_req(RO_BASE + 4 * i, 1'b1, 4'hf, $urandom(), 1'b0);
        2: issue_req(a, 1'b0, 4'hf, 32'h0, 1'b0);
        default: issue_req(MEM_WORDS * 4 + 4 * i, 1'b0, 4'hf, 32'h0, 1'b0);
      endcase
    end
    wait_drain();
  endtask

  initial begin
    void'($urandom(29));
    clk       = 1'b0;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req_addr  = '0;
    req_we    = 1'b0;
    req_be    = '0;
    req_wdata = '0;
    wpt_wait  = 1'b0;
    cfg_we    = 1'b0;
    cfg_idx   = '0;
    cfg_addr  = '0;
    cfg_load  = 1'b0;
    cfg_store = 1'b0;
    cfg_en    = 1'b0;
    // The simulated memory starts cleared
    for (int i = 0; i < MEM_WORDS; i++) model_mem[i] = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    test_rw_random();
    test_ro_region();
    test_out_of_range();
    test_wpt_wait();
    test_wpt_nowait();
    test_back_to_back();
    // Every expected response has been seen by now, a missing one ends in the timeout
    $display("All checks passed");
    $finish;
  end

endmodule

//--- hdl/data_subsys_top.sv
/*
 * Data subsystem top level
 * Core port through watchpoint filter and MPU to the data memory
 */

`timescale 1ns/1ps

module data_subsys_top #(
  parameter int unsigned                NUM_WPT         = 2,
  parameter logic [lsu_pkg::ADDR_W-1:0] RO_BASE         = 'h100,
  parameter int unsigned                MEM_WORDS       = 128,
  parameter int unsigned                MAX_OUTSTANDING = 2,
  localparam int unsigned IDX_W = (NUM_WPT > 1) ? $clog2(NUM_WPT) : 1
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  logic [lsu_pkg::ADDR_W-1:0] req_addr_i,
  input  logic                       req_we_i,
  input  logic [3:0]                 req_be_i,
  input  logic [31:0]                req_wdata_i,
  output logic                       resp_valid_o,
  output logic [31:0]                resp_rdata_o,
  output logic                       resp_err_o,
  output lsu_pkg::mpu_status_e       resp_mpu_status_o,
  output logic                       resp_wpt_match_o,
  input  logic                       wpt_wait_i,
  output logic                       wpt_match_o,
  input  logic                       cfg_we_i,
  input  logic [IDX_W-1:0]           cfg_idx_i,
  input  logic [lsu_pkg::ADDR_W-1:0] cfg_addr_i,
  input  logic                       cfg_load_i,
  input  logic                       cfg_store_i,
  input  logic                       cfg_en_i
);

  lsu_pkg::data_req_t  core_req;
  lsu_pkg::data_resp_t core_resp;
  lsu_pkg::data_resp_t mpu_resp;
  lsu_pkg::bus_resp_t  mem_resp;
  logic                mpu_resp_valid;
  logic                mem_resp_valid;
  logic                trig_match;
  logic                filt_ready;
  logic                req_valid;
  logic                core_accept;
  logic                one_pend_n;
  logic                cnt_full;

  data_req_if core_if ();
  data_req_if bus_if ();

  assign core_req = '{addr: req_addr_i, we: req_we_i, be: req_be_i, wdata: req_wdata_i};

  // The counter limit holds requests back at the core port
  assign req_valid   = req_valid_i && !cnt_full;
  assign req_ready_o = filt_ready && !cnt_full;

  // A match consumed without waiting is never answered, so it is not counted
  assign core_accept = req_valid && req_ready_o && !(trig_match && !wpt_wait_i);

  assign resp_rdata_o      = core_resp.bus_resp.rdata;
  assign resp_err_o        = core_resp.bus_resp.err;
  assign resp_mpu_status_o = core_resp.mpu_status;
  assign resp_wpt_match_o  = core_resp.wpt_match;

  wpt_trigger #(.NUM_WPT(NUM_WPT)) u_wpt_trigger (
    .clk, .rst_n, .cfg_we_i, .cfg_idx_i, .cfg_addr_i, .cfg_load_i, .cfg_store_i, .cfg_en_i,
    .req_valid_i(req_valid), .req_i(core_req), .match_o(trig_match)
  );

  wpt_filter u_wpt_filter (
    .clk, .rst_n, .trigger_match_i(trig_match),
    .core_trans_valid_i(req_valid), .core_trans_ready_o(filt_ready), .core_trans_i(core_req),
    .core_resp_valid_o(resp_valid_o), .core_resp_o(core_resp),
    .core_one_txn_pend_n(one_pend_n), .core_wpt_wait_i(wpt_wait_i),
    .core_wpt_match_o(wpt_match_o), .mpu_if(core_if.initiator),
    .mpu_resp_valid_i(mpu_resp_valid), .mpu_resp_i(mpu_resp)
  );

  data_mpu #(.RO_BASE(RO_BASE)) u_data_mpu (
    .clk, .rst_n, .core_if(core_if.target),
    .core_resp_valid_o(mpu_resp_valid), .core_resp_o(mpu_resp),
    .bus_if(bus_if.initiator), .bus_resp_valid_i(mem_resp_valid), .bus_resp_i(mem_resp)
  );

  txn_counter #(.MAX_OUTSTANDING(MAX_OUTSTANDING)) u_txn_counter (
    .clk, .rst_n, .accept_i(core_accept), .resp_i(resp_valid_o),
    .one_txn_pend_n_o(one_pend_n), .full_o(cnt_full)
  );

  data_mem #(.MEM_WORDS(MEM_WORDS)) u_data_mem (
    .clk, .rst_n, .bus_if(bus_if.target),
    .resp_valid_o(mem_resp_valid), .resp_o(mem_resp)
  );

endmodule

//--- hdl/data_mem.sv
/*
 * Data memory
 * Byte-enabled word array answering every transfer one cycle later
 */

`timescale 1ns/1ps

module data_mem #(
  parameter int unsigned MEM_WORDS = 128,
  localparam int unsigned MEM_AW   = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1
) (
  input  logic               clk,
  input  logic               rst_n,
  data_req_if.target         bus_if,
  output logic               resp_valid_o,
  output lsu_pkg::bus_resp_t resp_o
);

  logic [31:0]                  mem [MEM_WORDS];
  logic [lsu_pkg::ADDR_W-3:0]   word_idx;
  logic                         in_range;
  logic                         xfer;

  // Never stalls, so the response timing is fixed
  assign bus_if.ready = 1'b1;
  assign xfer         = bus_if.valid && bus_if.ready;

  assign word_idx = bus_if.req.addr[lsu_pkg::ADDR_W-1:2];
  assign in_range = (word_idx < MEM_WORDS);

  // A write returns the word as it stood before the write
  always_ff @(posedge clk) begin
    if (xfer) begin
      resp_o.rdata <= in_range ? mem[word_idx[MEM_AW-1:0]] : '0;
      resp_o.err   <= !in_range;
      if (bus_if.req.we && in_range) begin
        for (int b = 0; b < 4; b++) begin
          if (bus_if.req.be[b]) begin
            mem[word_idx[MEM_AW-1:0]][8*b +: 8] <= bus_if.req.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  // One response pulse per transfer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= xfer;
    end
  end

endmodule

//--- hdl/txn_counter.sv
/*
 * Outstanding transaction counter
 * Tracks accepted but unanswered requests and predicts the next-cycle count
 */

`timescale 1ns/1ps

module txn_counter #(
  parameter int unsigned MAX_OUTSTANDING = 2,
  localparam int unsigned CNT_W          = $clog2(MAX_OUTSTANDING + 1)
) (
  input  logic clk,
  input  logic rst_n,
  input  logic accept_i,
  input  logic resp_i,
  output logic one_txn_pend_n_o,
  output logic full_o
);

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_n;

  // An acceptance and a response in the same cycle cancel out
  assign cnt_n = cnt_q + CNT_W'(accept_i) - CNT_W'(resp_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_n;
    end
  end

  // The filter acts a cycle later and so looks at the next-cycle count
  assign one_txn_pend_n_o = (cnt_n == CNT_W'(1));
  assign full_o           = (cnt_q == CNT_W'(MAX_OUTSTANDING));

  a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n)
    resp_i |-> (cnt_q != '0));
  a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
    (accept_i && !resp_i) |-> (cnt_q < CNT_W'(MAX_OUTSTANDING)));

endmodule

//--- hdl/data_mpu.sv
/*
 * Data MPU
 * Forwards permitted requests to memory and answers writes into the
 * read-only region itself with a write fault status
 */

`timescale 1ns/1ps

module data_mpu #(
  parameter logic [lsu_pkg::ADDR_W-1:0] RO_BASE = 'h100
) (
  input  logic                clk,
  input  logic                rst_n,
  data_req_if.target          core_if,
  output logic                core_resp_valid_o,
  output lsu_pkg::data_resp_t core_resp_o,
  data_req_if.initiator       bus_if,
  input  logic                bus_resp_valid_i,
  input  lsu_pkg::bus_resp_t  bus_resp_i
);

  logic wr_fault;
  logic fault_accept;
  logic fault_resp_q;

  // Any write at or above the base of the read-only region faults
  assign wr_fault = core_if.req.we && (core_if.req.addr >= RO_BASE);

  // Nothing is taken while a fault response goes out
  // A faulting write is acknowledged here and never reaches the bus
  assign core_if.ready = !fault_resp_q && (wr_fault || bus_if.ready);
  assign fault_accept  = core_if.valid && core_if.ready && wr_fault;

  assign bus_if.valid = core_if.valid && !wr_fault && !fault_resp_q;
  assign bus_if.req   = core_if.req;

  // Fault response follows its acceptance by one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fault_resp_q <= 1'b0;
    end else begin
      fault_resp_q <= fault_accept;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response merge
  ////////////////////////////////////////////////////////////////////////////

  // Bus responses come back wrapped with an OK status
  assign core_resp_valid_o = bus_resp_valid_i || fault_resp_q;

  always_comb begin
    core_resp_o.bus_resp   = bus_resp_i;
    core_resp_o.mpu_status = lsu_pkg::MPU_OK;
    core_resp_o.wpt_match  = 1'b0;
    if (fault_resp_q) begin
      core_resp_o.bus_resp   = '0;
      core_resp_o.mpu_status = lsu_pkg::MPU_WR_FAULT;
    end
  end

endmodule

//--- hdl/wpt_filter.sv
/*
 * Watchpoint filter
 * Consumes requests whose trigger fires and, once older traffic has drained,
 * answers them with a watchpoint response merged into the response stream
 */

`timescale 1ns/1ps

module wpt_filter (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 trigger_match_i,
  input  logic                 core_trans_valid_i,
  output logic                 core_trans_ready_o,
  input  lsu_pkg::data_req_t   core_trans_i,
  output logic                 core_resp_valid_o,
  output lsu_pkg::data_resp_t  core_resp_o,
  input  logic                 core_one_txn_pend_n,
  input  logic                 core_wpt_wait_i,
  output logic                 core_wpt_match_o,
  data_req_if.initiator        mpu_if,
  input  logic                 mpu_resp_valid_i,
  input  lsu_pkg::data_resp_t  mpu_resp_i
);

  logic                wpt_block_core;
  logic                wpt_block_bus;
  logic                wpt_trans_ready;
  logic                wpt_trans_valid;
  lsu_pkg::wpt_state_e state_q;
  lsu_pkg::wpt_state_e state_n;

  ////////////////////////////////////////////////////////////////////////////
  // Match FSM
  ////////////////////////////////////////////////////////////////////////////

  // A matching request is taken from the core but never reaches the MPU
  // In wait mode the FSM then holds off new requests until only the consumed
  // one is left in flight, and answers it in the following cycle
  always_comb begin
    state_n         = state_q;
    wpt_block_core  = 1'b0;
    wpt_block_bus   = 1'b0;
    wpt_trans_ready = 1'b0;
    wpt_trans_valid = 1'b0;

    case (state_q)
      lsu_pkg::WPT_IDLE: begin
        if (trigger_match_i && core_trans_valid_i) begin
          // Accept locally and keep it off the bus
          wpt_block_bus   = 1'b1;
          wpt_trans_ready = 1'b1;
          if (core_wpt_wait_i) begin
            state_n = core_one_txn_pend_n ? lsu_pkg::WPT_MATCH_RESP
                                          : lsu_pkg::WPT_MATCH_WAIT;
          end
        end
      end
      lsu_pkg::WPT_MATCH_WAIT: begin
        // Older requests are still draining
        wpt_block_bus  = 1'b1;
        wpt_block_core = 1'b1;
        if (core_one_txn_pend_n) begin
          state_n = lsu_pkg::WPT_MATCH_RESP;
        end
      end
      lsu_pkg::WPT_MATCH_RESP: begin
        wpt_block_bus   = 1'b1;
        wpt_block_core  = 1'b1;
        wpt_trans_valid = 1'b1;
        // The core always takes the response, so one cycle is enough
        state_n         = lsu_pkg::WPT_IDLE;
      end
      default: begin
        state_n = lsu_pkg::WPT_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= lsu_pkg::WPT_IDLE;
    end else begin
      state_q <= state_n;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request and response paths
  ////////////////////////////////////////////////////////////////////////////

  assign mpu_if.valid = core_trans_valid_i && !wpt_block_bus;
  assign mpu_if.req   = core_trans_i;

  assign core_trans_ready_o = (mpu_if.ready && !wpt_block_core) || wpt_trans_ready;

  // The watchpoint response carries no bus data and a clean MPU status
  assign core_resp_valid_o = mpu_resp_valid_i || wpt_trans_valid;
  always_comb begin
    core_resp_o = mpu_resp_i;
    if (wpt_trans_valid) begin
      core_resp_o.bus_resp   = '0;
      core_resp_o.mpu_status = lsu_pkg::MPU_OK;
    end
    core_resp_o.wpt_match = wpt_trans_valid;
  end

  // The core uses this immediate report when it does not wait
  assign core_wpt_match_o = trigger_match_i;

  // Draining guarantees the MPU is silent when the filter answers
  a_resp_exclusive : assert property (@(posedge clk) disable iff (!rst_n)
    !(mpu_resp_valid_i && wpt_trans_valid));

endmodule

//--- hdl/wpt_trigger.sv
/*
 * Watchpoint trigger unit
 * Programmable word address comparators that flag a match on the live request
 */

`timescale 1ns/1ps

module wpt_trigger #(
  parameter int unsigned NUM_WPT = 2,
  localparam int unsigned IDX_W  = (NUM_WPT > 1) ? $clog2(NUM_WPT) : 1
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       cfg_we_i,
  input  logic [IDX_W-1:0]           cfg_idx_i,
  input  logic [lsu_pkg::ADDR_W-1:0] cfg_addr_i,
  input  logic                       cfg_load_i,
  input  logic                       cfg_store_i,
  input  logic                       cfg_en_i,
  input  logic                       req_valid_i,
  input  lsu_pkg::data_req_t         req_i,
  output logic                       match_o
);

  // Per entry watch address and control flags
  logic [lsu_pkg::ADDR_W-1:0] addr_q [NUM_WPT];
  logic [NUM_WPT-1:0]         en_q;
  logic [NUM_WPT-1:0]         load_q;
  logic [NUM_WPT-1:0]         store_q;

  // Control flags come up cleared so no entry fires after reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      en_q    <= '0;
      load_q  <= '0;
      store_q <= '0;
    end else begin
      for (int i = 0; i < NUM_WPT; i++) begin
        if (cfg_we_i && (cfg_idx_i == IDX_W'(i))) begin
          en_q[i]    <= cfg_en_i;
          load_q[i]  <= cfg_load_i;
          store_q[i] <= cfg_store_i;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_WPT; i++) begin
      if (cfg_we_i && (cfg_idx_i == IDX_W'(i))) begin
        addr_q[i] <= cfg_addr_i;
      end
    end
  end

  // Compare on word address and ignore the byte offset
  always_comb begin
    match_o = 1'b0;
    for (int i = 0; i < NUM_WPT; i++) begin
      if (req_valid_i && en_q[i] &&
          (addr_q[i][lsu_pkg::ADDR_W-1:2] == req_i.addr[lsu_pkg::ADDR_W-1:2]) &&
          (req_i.we ? store_q[i] : load_q[i])) begin
        match_o = 1'b1;
      end
    end
  end

  // Configuration writes must address an existing entry
  a_cfg_idx_range : assert property (@(posedge clk) disable iff (!rst_n)
    cfg_we_i |-> (cfg_idx_i < NUM_WPT));

endmodule

//--- hdl/data_req_if.sv
/*
 * Data request channel
 * Valid/ready handshake carrying one data request from initiator to target
 */

`timescale 1ns/1ps

interface data_req_if;

  // A transfer takes place on a clock edge where valid and ready are both high
  logic               valid;
  logic               ready;
  lsu_pkg::data_req_t req;

  // The initiator holds req and valid stable until ready is seen
  modport initiator (
    output valid,
    output req,
    input  ready
  );

  // The target only decides when to take the request
  modport target (
    input  valid,
    input  req,
    output ready
  );

endinterface

//--- hdl/lsu_pkg.sv
/*
 * Load/store unit package
 * Shared request and response types, MPU status and watchpoint filter states
 */

package lsu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Addresses are byte addresses, one word wide
  localparam int unsigned ADDR_W = 32;

  ////////////////////////////////////////////////////////////////////////////
  // Request and response types
  ////////////////////////////////////////////////////////////////////////////

  // One data request as the core issues it
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [3:0]        be;
    logic [31:0]       wdata;
  } data_req_t;

  // Raw answer from the memory
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } bus_resp_t;

  // Verdict of the data MPU on a request
  typedef enum logic [1:0] {
    MPU_OK       = 2'b00,
    MPU_WR_FAULT = 2'b01
  } mpu_status_e;

  // Response as the core sees it, with MPU and watchpoint status attached
  typedef struct packed {
    bus_resp_t   bus_resp;
    mpu_status_e mpu_status;
    logic        wpt_match;
  } data_resp_t;

  // States of the watchpoint filter FSM
  typedef enum logic [1:0] {
    WPT_IDLE       = 2'b00,
    WPT_MATCH_WAIT = 2'b01,
    WPT_MATCH_RESP = 2'b10
  } wpt_state_e;

endpackage
